//--- flist.f
+incdir+verilog
verilog/hamming_pkg.sv
verilog/hamming_encoder.sv
verilog/hamming_decoder.sv
verilog/hs_req_ack.sv
verilog/hamming_codec_top.sv
verif/hamming_codec_asserts.sv
verif/hamming_codec_tb.sv

//--- verif/hamming_codec_asserts.sv
// Handshake and reset checks for both codec channels, bound into the top level
module hamming_codec_asserts (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     enc_req,
    input logic                     enc_ack,
    input hamming_pkg::code_t       enc_code,
    input logic                     dec_req,
    input logic                     dec_ack,
    input hamming_pkg::data_t       dec_data,
    input hamming_pkg::dec_status_e dec_status
);

    int unsigned err_count = 0;

    a_ack_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !enc_ack && !dec_ack)
        else begin
            err_count++;
            $error("ack high when reset was released");
        end

    // ack may only fall once req is low
    a_enc_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
        enc_ack && enc_req |=> enc_ack)
        else begin
            err_count++;
            $error("enc_ack dropped while enc_req was still high");
        end
    a_dec_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dec_ack && dec_req |=> dec_ack)
        else begin
            err_count++;
            $error("dec_ack dropped while dec_req was still high");
        end

    a_enc_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(enc_req) |-> ##[1:8] enc_ack)
        else begin
            err_count++;
            $error("enc_ack did not rise within 8 cycles of enc_req");
        end
    a_dec_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(dec_req) |-> ##[1:8] dec_ack)
        else begin
            err_count++;
            $error("dec_ack did not rise within 8 cycles of dec_req");
        end

    a_enc_stable: assert property (@(posedge clk) disable iff (!arst_n)
        enc_ack |=> $stable(enc_code))
        else begin
            err_count++;
            $error("enc_code changed while enc_ack was high");
        end
    a_dec_stable: assert property (@(posedge clk) disable iff (!arst_n)
        dec_ack |=> $stable({dec_data, dec_status}))
        else begin
            err_count++;
            $error("decode result changed while dec_ack was high");
        end

endmodule

bind hamming_codec_top hamming_codec_asserts u_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .enc_req   (enc_req),
    .enc_ack   (enc_ack),
    .enc_code  (enc_code),
    .dec_req   (dec_req),
    .dec_ack   (dec_ack),
    .dec_data  (dec_data),
    .dec_status(dec_status)
);

//--- verif/hamming_codec_tb.sv
// Hamming codec testbench with random encode and decode traffic against a reference model
`include "hamming_consts.svh"

module hamming_codec_tb;
    import hamming_pkg::*;

    localparam int N_TXN = 300;   // per channel
    localparam int WATCHDOG_T = (N_TXN + 1) * 20 * 10 * 2;
    localparam logic [31:0] SEED = 32'hb1ea761f;

    logic        clk;
    logic        arst_n;
    logic        enc_req;
    code_mode_e  enc_mode;
    data_t       enc_data;
    logic        enc_ack;
    code_t       enc_code;
    logic        dec_req;
    code_mode_e  dec_mode;
    code_t       dec_code_in;
    logic        dec_ack;
    data_t       dec_data;
    dec_status_e dec_status;

    hamming_codec_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .enc_req    (enc_req),
        .enc_mode   (enc_mode),
        .enc_data   (enc_data),
        .enc_ack    (enc_ack),
        .enc_code   (enc_code),
        .dec_req    (dec_req),
        .dec_mode   (dec_mode),
        .dec_code_in(dec_code_in),
        .dec_ack    (dec_ack),
        .dec_data   (dec_data),
        .dec_status (dec_status)
    );

    always #5 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic compare_code(string name, code_t exp, code_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic compare_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic compare_status(string name, dec_status_e exp, dec_status_e act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %s got %s (%b)",
                                $time, name, exp.name(), act.name(), act));
        end
    endtask

    // last Hamming position of each mode
    function automatic int span(code_mode_e mode);
        if (mode == MODE_7_4) return 7;
        if (mode == MODE_15_11) return 15;
        return 31;
    endfunction

    // parity bits are set to the syndrome of the data-only word, zeroing it
    function automatic code_t model_encode(code_mode_e mode, data_t data);
        int         n;
        int         k;
        logic [4:0] syn;
        code_t      c;
        n   = span(mode);
        k   = 0;
        syn = '0;
        c   = '0;
        for (int p = 3; p <= n; p++) begin
            if ((p & (p - 1)) != 0) begin
                c[p-1] = data[k];
                if (data[k]) syn ^= 5'(p);
                k++;
            end
        end
        for (int i = 0; (1 << i) <= n; i++) begin
            c[(1 << i) - 1] = syn[i];
        end
        if (mode == MODE_SECDED) c[`HAM_CODE_W-1] = ^c[`HAM_CODE_W-2:0];
        return c;
    endfunction

    function automatic dec_rsp_t model_decode(code_mode_e mode, code_t code);
        int         n;
        int         k;
        logic [4:0] syn;
        code_t      c;
        dec_rsp_t   r;
        n   = span(mode);
        syn = '0;
        c   = '0;
        for (int p = 1; p <= n; p++) begin
            c[p-1] = code[p-1];
            if (code[p-1]) syn ^= 5'(p);
        end
        r.status = ST_OK;
        if (mode != MODE_SECDED || ^code) begin
            if (syn != '0) c[syn-1] = ~c[syn-1];
            if (syn != '0 || mode == MODE_SECDED) r.status = ST_CORRECTED;
        end else if (syn != '0) begin
            r.status = ST_UNCORRECTABLE;   // even parity, two bits hit
        end
        r.data = '0;
        k      = 0;
        for (int p = 3; p <= n; p++) begin
            if ((p & (p - 1)) != 0) begin
                r.data[k] = c[p-1];
                k++;
            end
        end
        return r;
    endfunction

    task automatic idle_gap();
        repeat ($urandom_range(5, 0)) @(negedge clk);
    endtask

    task automatic run_encode();
        code_mode_e mode;
        data_t      data;
        code_t      exp;
        mode = code_mode_e'($urandom_range(3, 0));
        data = data_t'($urandom);   // upper bits must be ignored
        exp  = model_encode(mode, data);
        idle_gap();
        enc_mode = mode;
        enc_data = data;
        enc_req  = 1'b1;
        while (!enc_ack) @(negedge clk);
        compare_code("enc_code", exp, enc_code);
        repeat ($urandom_range(5, 0)) begin   // requester hold
            @(negedge clk);
            compare_code("enc_code", exp, enc_code);
        end
        enc_req  = 1'b0;
        enc_data = data_t'($urandom);
        while (enc_ack) @(negedge clk);
    endtask

    task automatic run_decode(int idx);
        code_mode_e mode;
        data_t      data;
        code_t      code;
        dec_rsp_t   exp;
        int         len;
        int         kind;
        int         a;
        int         b;
        kind = idx % 3;   // clean, one flip, two flips
        mode = (kind == 2) ? MODE_SECDED : code_mode_e'($urandom_range(3, 0));
        data = data_t'($urandom);
        code = model_encode(mode, data);
        len  = (mode == MODE_SECDED) ? 32 : span(mode);
        a    = $urandom_range(len - 1, 0);
        if (kind == 1 && mode == MODE_SECDED && (idx % 4) == 1) a = 31;
        b    = (a + 1 + $urandom_range(len - 2, 0)) % len;
        if (kind >= 1) code[a] = ~code[a];
        if (kind == 2) code[b] = ~code[b];
        exp = model_decode(mode, code);
        idle_gap();
        dec_mode    = mode;
        dec_code_in = code;
        dec_req     = 1'b1;
        while (!dec_ack) @(negedge clk);
        repeat ($urandom_range(5, 0) + 1) begin
            compare_status("dec_status", exp.status, dec_status);
            if (exp.status != ST_UNCORRECTABLE) compare_data("dec_data", exp.data, dec_data);
            @(negedge clk);
        end
        dec_req     = 1'b0;
        dec_code_in = code_t'($urandom);
        while (dec_ack) @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_T);
        abort_run("watchdog timeout, a handshake did not complete in time");
    end

    initial begin
        wait (DUT.u_asserts.err_count != 0);
        abort_run("a bound handshake or reset assertion failed");
    end

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        arst_n      = 1'b0;
        enc_req     = 1'b0;
        enc_mode    = MODE_7_4;
        enc_data    = '0;
        dec_req     = 1'b0;
        dec_mode    = MODE_7_4;
        dec_code_in = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        compare_flag("enc_ack", 1'b0, enc_ack);
        compare_flag("dec_ack", 1'b0, dec_ack);
        fork
            begin
                for (int i = 0; i < N_TXN; i++) run_encode();
            end
            begin
                for (int i = 0; i < N_TXN; i++) run_decode(i);
            end
        join
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog/hamming_codec_top.sv
// Hamming codec top level with separate encode and decode req/ack channels
module hamming_codec_top (
    input  logic                     clk,
    input  logic                     arst_n,
    // encode channel
    input  logic                     enc_req,
    input  hamming_pkg::code_mode_e  enc_mode,
    input  hamming_pkg::data_t       enc_data,
    output logic                     enc_ack,
    output hamming_pkg::code_t       enc_code,
    // decode channel
    input  logic                     dec_req,
    input  hamming_pkg::code_mode_e  dec_mode,
    input  hamming_pkg::code_t       dec_code_in,
    output logic                     dec_ack,
    output hamming_pkg::data_t       dec_data,
    output hamming_pkg::dec_status_e dec_status
);
    import hamming_pkg::*;

    enc_req_t    enc_payload;
    enc_req_t    enc_core_req;
    logic        enc_core_valid;
    logic        enc_core_done;
    code_t       enc_core_code;

    dec_req_t    dec_payload;
    dec_req_t    dec_core_req;
    logic        dec_core_valid;
    logic        dec_core_done;
    data_t       dec_core_data;
    dec_status_e dec_core_status;
    dec_rsp_t    dec_core_rsp;
    dec_rsp_t    dec_rsp;

    assign enc_payload  = '{mode: enc_mode, data: enc_data};
    assign dec_payload  = '{mode: dec_mode, code: dec_code_in};
    assign dec_core_rsp = '{data: dec_core_data, status: dec_core_status};
    assign dec_data     = dec_rsp.data;
    assign dec_status   = dec_rsp.status;

    hs_req_ack #(
        .req_t(enc_req_t),
        .rsp_t(code_t)
    ) u_enc_hs (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (enc_req),
        .req_data  (enc_payload),
        .ack       (enc_ack),
        .rsp_data  (enc_code),
        .core_valid(enc_core_valid),
        .core_req  (enc_core_req),
        .core_done (enc_core_done),
        .core_rsp  (enc_core_code)
    );

    hamming_encoder u_enc (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (enc_core_valid),
        .in_mode  (enc_core_req.mode),
        .in_data  (enc_core_req.data),
        .out_valid(enc_core_done),
        .out_code (enc_core_code)
    );

    hs_req_ack #(
        .req_t(dec_req_t),
        .rsp_t(dec_rsp_t)
    ) u_dec_hs (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (dec_req),
        .req_data  (dec_payload),
        .ack       (dec_ack),
        .rsp_data  (dec_rsp),
        .core_valid(dec_core_valid),
        .core_req  (dec_core_req),
        .core_done (dec_core_done),
        .core_rsp  (dec_core_rsp)
    );

    hamming_decoder u_dec (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (dec_core_valid),
        .in_mode   (dec_core_req.mode),
        .in_code   (dec_core_req.code),
        .out_valid (dec_core_done),
        .out_data  (dec_core_data),
        .out_status(dec_core_status)
    );

endmodule

//--- verilog/hamming_consts.svh
// Hamming codec word widths and core pipeline latencies
`ifndef HAMMING_CONSTS_SVH
`define HAMMING_CONSTS_SVH

// widest data word, SECDED and (31,26)
`define HAM_DATA_W 26

// code word width, bit p-1 holds position p
`define HAM_CODE_W 32

// cycles from in_valid to out_valid
`define HAM_ENC_LAT 2
`define HAM_DEC_LAT 3

`endif

//--- verilog/hamming_decoder.sv
// Hamming and SECDED decoder with syndrome, correction and extraction stages
`include "hamming_consts.svh"

module hamming_decoder (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  hamming_pkg::code_mode_e  in_mode,
    input  hamming_pkg::code_t       in_code,
    output logic                     out_valid,
    output hamming_pkg::data_t       out_data,
    output hamming_pkg::dec_status_e out_status
);
    import hamming_pkg::*;

    localparam int SYN_W = $clog2(`HAM_CODE_W);

    // stage one
    code_t            code_m;
    logic [SYN_W-1:0] syn_d;
    logic             v1_q;
    code_mode_e       mode1_q;
    code_t            code1_q;
    logic [SYN_W-1:0] syn_q;
    logic             ovp_q;

    // stage two
    logic             flip;
    code_t            code_fix;
    dec_status_e      st_d;
    logic             v2_q;
    code_mode_e       mode2_q;
    code_t            code2_q;
    dec_status_e      st2_q;

    // stage three
    data_t            data_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v1_q      <= 1'b0;
            v2_q      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            v1_q      <= in_valid;
            v2_q      <= v1_q;
            out_valid <= v2_q;
        end
    end

    // mask to the code length and form the syndrome
    always_comb begin
        int unsigned n;
        n      = code_len(in_mode);
        code_m = '0;
        syn_d  = '0;
        for (int p = 1; p < `HAM_CODE_W; p++) begin
            if (p <= n) begin
                code_m[p-1] = in_code[p-1];
                if (in_code[p-1]) begin
                    syn_d ^= SYN_W'(p);
                end
            end
        end
        if (in_mode == MODE_SECDED) begin
            code_m[`HAM_CODE_W-1] = in_code[`HAM_CODE_W-1];
        end
    end

    always_ff @(posedge clk) begin
        mode1_q <= in_mode;
        code1_q <= code_m;
        syn_q   <= syn_d;
        ovp_q   <= (in_mode == MODE_SECDED) && (^code_m);   // odd overall parity
    end

    // single error correction and status
    always_comb begin
        flip     = (syn_q != '0) && ((mode1_q != MODE_SECDED) || ovp_q);
        code_fix = code1_q;
        st_d     = ST_OK;
        if (flip) begin
            code_fix[syn_q - 1'b1] = ~code1_q[syn_q - 1'b1];
            st_d                   = ST_CORRECTED;
        end else if (ovp_q) begin
            st_d = ST_CORRECTED;   // only the overall parity bit was hit
        end else if (mode1_q == MODE_SECDED && syn_q != '0) begin
            st_d = ST_UNCORRECTABLE;   // double error, leave word alone
        end
    end

    always_ff @(posedge clk) begin
        mode2_q <= mode1_q;
        code2_q <= code_fix;
        st2_q   <= st_d;
    end

    // pull data back out of the non-power-of-two positions
    always_comb begin
        int unsigned n;
        int unsigned k;
        n      = code_len(mode2_q);
        k      = 0;
        data_d = '0;
        for (int p = 1; p < `HAM_CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (p <= n) begin
                    data_d[k] = code2_q[p-1];
                end
                k++;
            end
        end
    end

    always_ff @(posedge clk) begin
        out_data   <= data_d;
        out_status <= st2_q;
    end

endmodule

//--- verilog/hamming_encoder.sv
// Hamming and SECDED encoder with a two-stage fixed-latency pipeline
`include "hamming_consts.svh"

module hamming_encoder (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  hamming_pkg::code_mode_e in_mode,
    input  hamming_pkg::data_t      in_data,
    output logic                    out_valid,
    output hamming_pkg::code_t      out_code
);
    import hamming_pkg::*;

    localparam int PAR_N = $clog2(`HAM_CODE_W);   // parity positions 1,2,4,8,16

    logic       valid_q;
    code_mode_e mode_q;
    data_t      data_q;
    code_t      code_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    // input buffer stage
    always_ff @(posedge clk) begin
        mode_q <= in_mode;
        data_q <= in_data;
    end

    always_comb begin
        int unsigned n;
        int unsigned k;
        logic        par;
        n         = code_len(mode_q);
        k         = 0;
        code_next = '0;

        // data in ascending order at the non-power-of-two positions
        for (int p = 1; p < `HAM_CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (p <= n) begin
                    code_next[p-1] = data_q[k];
                end
                k++;   // same slot order in every mode
            end
        end

        // parity bit at position 2**i covers all positions with bit i set
        for (int i = 0; i < PAR_N; i++) begin
            par = 1'b0;
            for (int p = 1; p < `HAM_CODE_W; p++) begin
                if ((p & (1 << i)) != 0) begin
                    par ^= code_next[p-1];
                end
            end
            if ((1 << i) <= n) begin
                code_next[(1 << i) - 1] = par;
            end
        end

        if (mode_q == MODE_SECDED) begin
            code_next[`HAM_CODE_W-1] = ^code_next[`HAM_CODE_W-2:0];   // overall parity
        end
    end

    // output stage
    always_ff @(posedge clk) begin
        out_code <= code_next;
    end

endmodule

//--- verilog/hamming_pkg.sv
// Hamming codec shared modes, status codes and channel payload types
package hamming_pkg;
    `include "hamming_consts.svh"

    typedef enum logic [1:0] {
        MODE_7_4    = 2'd0,
        MODE_15_11  = 2'd1,
        MODE_31_26  = 2'd2,
        MODE_SECDED = 2'd3   // (31,26) plus overall parity in bit 31
    } code_mode_e;

    typedef logic [`HAM_DATA_W-1:0] data_t;
    typedef logic [`HAM_CODE_W-1:0] code_t;

    typedef enum logic [1:0] {
        ST_OK            = 2'd0,
        ST_CORRECTED     = 2'd1,
        ST_UNCORRECTABLE = 2'd2
    } dec_status_e;

    typedef struct packed {
        code_mode_e mode;
        data_t      data;
    } enc_req_t;

    typedef struct packed {
        code_mode_e mode;
        code_t      code;
    } dec_req_t;

    typedef struct packed {
        data_t       data;
        dec_status_e status;
    } dec_rsp_t;

    // highest Hamming position in use, SECDED parity bit not counted
    function automatic int unsigned code_len(code_mode_e mode);
        case (mode)
            MODE_7_4:   return 7;
            MODE_15_11: return 15;
            default:    return 31;
        endcase
    endfunction
endpackage

//--- verilog/hs_req_ack.sv
// Four-phase req/ack slave running one request through a fixed-latency core
module hs_req_ack #(
    parameter type req_t = logic,
    parameter type rsp_t = logic
) (
    input  logic clk,
    input  logic arst_n,
    input  logic req,
    input  req_t req_data,
    output logic ack,
    output rsp_t rsp_data,
    output logic core_valid,
    output req_t core_req,
    input  logic core_done,
    input  rsp_t core_rsp
);

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_BUSY  = 2'd1,   // item inside the core
        S_ACKED = 2'd2    // result held, waiting for req low
    } state_e;

    state_e state;
    logic   take;
    logic   capture;

    assign take    = (state == S_IDLE) && req && !ack;
    assign capture = (state == S_BUSY) && core_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            core_valid <= 1'b0;
            ack        <= 1'b0;
        end else begin
            core_valid <= take;               // one-cycle launch pulse
            ack        <= (state == S_ACKED);  // one edge behind the state
            case (state)
                S_IDLE: begin
                    if (take) begin
                        state <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    if (core_done) begin
                        state <= S_ACKED;
                    end
                end
                S_ACKED: begin
                    if (!req) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            core_req <= req_data;
        end
        if (capture) begin
            rsp_data <= core_rsp;   // stable until the next item
        end
    end

endmodule
